/* sim/tb_periph_soc.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_periph_soc;
    import wb_pkg::*;
    import soc_pkg::*;

    // About 230 transfers of 4 cycles each, plus reset and margin
    localparam int CYCLE_LIMIT = 4000;

    logic                 clk;
    logic                 rst_n_i;
    mem_req_t             mem_req;
    mem_rsp_t             mem_rsp;
    logic                 mem_stall;
    logic [GPIO_PINS-1:0] gpio_in;
    logic [GPIO_PINS-1:0] gpio_out;
    logic [GPIO_PINS-1:0] gpio_en;
    logic                 timer_irq;
    logic                 req_v;

    // Reference state read by the checkers
    logic [XLEN-1:0]      ram_model [DMEM_WORDS];
    logic [XLEN-1:0]      exp_rdata;
    logic                 exp_err;
    logic                 chk_rdata;
    logic [GPIO_PINS-1:0] exp_gpio_out;
    logic [GPIO_PINS-1:0] exp_gpio_en;
    logic [GPIO_PINS-1:0] exp_gpio_in;
    logic                 chk_mtime;
    logic [XLEN-1:0]      prev_mtime;
    logic                 chk_irq;
    logic                 irq_exp;

    logic [31:0] lfsr_state;
    int          err_cnt = 0;
    int          cycle_cnt = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    assign req_v = mem_req.read | mem_req.write;

    periph_soc_top u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .mem_req_i   (mem_req),
        .mem_rsp_o   (mem_rsp),
        .mem_stall_o (mem_stall),
        .gpio_i      (gpio_in),
        .gpio_o      (gpio_out),
        .gpio_en_o   (gpio_en),
        .timer_irq_o (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run reached the cycle limit of %0d cycles without finishing", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    // ============================================================
    // Checkers
    // ============================================================

    a_reset_state: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !mem_rsp.ack && !mem_rsp.err && !mem_stall
            && gpio_out == '0 && gpio_en == '0 && !timer_irq)
    else begin
        $display("Outputs were not at their reset values when reset was released");
        err_cnt++;
    end

    // Request seen, two stalled cycles, then the ack
    a_resp_timing: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(req_v) |-> (mem_stall && !mem_rsp.ack) ##1 (mem_stall && !mem_rsp.ack)
            ##1 (mem_rsp.ack && !mem_stall))
    else begin
        $display("Response did not come exactly two cycles after the request with stall high");
        err_cnt++;
    end

    a_err_with_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rsp.err |-> mem_rsp.ack)
    else begin
        $display("Error flag was raised without an ack");
        err_cnt++;
    end

    a_rsp_err: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rsp.ack |-> mem_rsp.err == exp_err)
    else begin
        $display("ERROR mem_rsp_o.err got %h expected %h", $sampled(mem_rsp.err),
                 $sampled(exp_err));
        err_cnt++;
    end

    a_rsp_rdata: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rsp.ack && chk_rdata |-> mem_rsp.rdata == exp_rdata)
    else begin
        $display("ERROR mem_rsp_o.rdata got %h expected %h", $sampled(mem_rsp.rdata),
                 $sampled(exp_rdata));
        err_cnt++;
    end

    a_gpio_out: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rsp.ack |-> gpio_out == exp_gpio_out)
    else begin
        $display("ERROR gpio_o got %h expected %h", $sampled(gpio_out), $sampled(exp_gpio_out));
        err_cnt++;
    end

    a_gpio_en: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rsp.ack |-> gpio_en == exp_gpio_en)
    else begin
        $display("ERROR gpio_en_o got %h expected %h", $sampled(gpio_en), $sampled(exp_gpio_en));
        err_cnt++;
    end

    a_mtime_incr: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rsp.ack && chk_mtime |-> mem_rsp.rdata > prev_mtime)
    else begin
        $display("ERROR mem_rsp_o.rdata got %h, expected a value above %h",
                 $sampled(mem_rsp.rdata), $sampled(prev_mtime));
        err_cnt++;
    end

    // Interrupt settles two cycles after the compare write
    a_timer_irq: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_rsp.ack && chk_irq |-> ##2 (timer_irq == irq_exp))
    else begin
        $display("ERROR timer_irq_o got %h expected %h", $sampled(timer_irq), $sampled(irq_exp));
        err_cnt++;
    end

    // ============================================================
    // Reference rules and stimulus helpers
    // ============================================================

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic mem_op_e pick_op(input logic [2:0] r);
        case (r)
            3'd0:    return MEM_B;
            3'd1:    return MEM_H;
            3'd3:    return MEM_BU;
            3'd4:    return MEM_HU;
            default: return MEM_W;
        endcase
    endfunction

    // Store lands on the lane picked by the low address bits
    function automatic logic [31:0] store_merge(input logic [31:0] old_w,
            input logic [31:0] wdata, input mem_op_e op, input logic [1:0] off);
        logic [31:0] res;
        res = old_w;
        case (op)
            MEM_B, MEM_BU: res[8*off +: 8] = wdata[7:0];
            MEM_H, MEM_HU: res[16*off[1] +: 16] = wdata[15:0];
            default:       res = wdata;
        endcase
        return res;
    endfunction

    function automatic logic [31:0] load_expect(input logic [31:0] word, input mem_op_e op,
            input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * off));
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            MEM_B:   return {{24{b[7]}}, b};
            MEM_BU:  return {24'h0, b};
            MEM_H:   return {{16{h[15]}}, h};
            MEM_HU:  return {16'h0, h};
            default: return word;
        endcase
    endfunction

    // Bits 27:10 are don't-care for the RAM index
    function automatic logic [31:0] ram_addr(input logic [5:0] idx);
        logic [17:0] alias_bits;
        logic [1:0]  off;
        alias_bits = 18'(rand_bits(18));
        off = 2'(rand_bits(2));
        return {DMEM_BASE, alias_bits, 2'b00, idx, off};
    endfunction

    task automatic xfer(input logic [31:0] addr, input logic [31:0] wdata, input mem_op_e op,
            input logic is_write, input logic chk, input logic [31:0] exp_rd,
            input logic exp_e, output logic [31:0] rd);
        int waited;
        @(posedge clk);
        exp_rdata = exp_rd;
        exp_err   = exp_e;
        chk_rdata = chk;
        mem_req.addr  <= addr;
        mem_req.wdata <= wdata;
        mem_req.op    <= op;
        mem_req.read  <= !is_write;
        mem_req.write <= is_write;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!mem_rsp.ack && waited < 8);
        if (!mem_rsp.ack) begin
            $display("No ack came for the transfer to address %h", addr);
            err_cnt++;
        end
        rd = mem_rsp.rdata;
        @(posedge clk);
        mem_req.read  <= 1'b0;
        mem_req.write <= 1'b0;
    endtask

    task automatic ram_access(input logic [31:0] addr, input logic [31:0] wdata,
            input mem_op_e op, input logic is_write);
        logic [7:0]  idx;
        logic [31:0] rd;
        idx = addr[9:2];
        if (is_write) begin
            ram_model[idx] = store_merge(ram_model[idx], wdata, op, addr[1:0]);
            xfer(addr, wdata, op, 1'b1, 1'b0, '0, 1'b0, rd);
        end else begin
            xfer(addr, '0, op, 1'b0, 1'b1, load_expect(ram_model[idx], op, addr[1:0]),
                 1'b0, rd);
        end
    endtask

    task automatic gpio_access(input logic [3:0] reg_off, input logic [1:0] lane,
            input logic [31:0] wdata, input mem_op_e op, input logic is_write);
        logic [31:0] addr;
        logic [31:0] cur;
        logic [31:0] rd;
        addr = {GPIO_BASE, 24'h0, reg_off[3:2], lane};
        if (reg_off == GPIO_OUT) begin
            cur = 32'(exp_gpio_out);
        end else if (reg_off == GPIO_EN) begin
            cur = 32'(exp_gpio_en);
        end else begin
            cur = 32'(exp_gpio_in);
        end
        if (is_write) begin
            cur = store_merge(cur, wdata, op, lane);
            if (reg_off == GPIO_OUT) begin
                exp_gpio_out = cur[GPIO_PINS-1:0];
            end else if (reg_off == GPIO_EN) begin
                exp_gpio_en = cur[GPIO_PINS-1:0];
            end
            xfer(addr, wdata, op, 1'b1, 1'b0, '0, 1'b0, rd);
        end else begin
            xfer(addr, '0, op, 1'b0, 1'b1, load_expect(cur, op, lane), 1'b0, rd);
        end
    endtask

    task automatic timer_write(input logic [3:0] reg_off, input logic [31:0] wdata);
        logic [31:0] rd;
        xfer({MTIMER_BASE, 24'h0, reg_off}, wdata, MEM_W, 1'b1, 1'b0, '0, 1'b0, rd);
        repeat (2) @(posedge clk);
    endtask

    // Lets the last checks of a test report before counting
    task automatic finish_test(input string name, input int errs_before);
        repeat (3) @(posedge clk);
        tests_run++;
        if (err_cnt != errs_before) begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", name, err_cnt - errs_before);
        end else begin
            $display("Test %s: pass", name);
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        logic [31:0] rd;
        logic [31:0] addr;
        logic [31:0] wdata;
        mem_op_e     op;
        logic        wr;
        int          errs;

        mem_req    <= '0;
        gpio_in    <= '0;
        rst_n_i    <= 1'b0;
        lfsr_state = 32'hf9d4;
        exp_rdata  = '0;
        exp_err    = 1'b0;
        chk_rdata  = 1'b0;
        chk_mtime  = 1'b0;
        prev_mtime = '0;
        chk_irq    = 1'b0;
        irq_exp    = 1'b0;
        exp_gpio_out = '0;
        exp_gpio_en  = '0;
        exp_gpio_in  = '0;

        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        errs = err_cnt;
        finish_test("reset values", errs);

        // Fill the low 64 words, then mixed sizes on them
        errs = err_cnt;
        for (int i = 0; i < 64; i++) begin
            addr  = ram_addr(6'(i));
            wdata = rand_bits(32);
            ram_access(addr, wdata, MEM_W, 1'b1);
        end
        for (int i = 0; i < 120; i++) begin
            op    = pick_op(3'(rand_bits(3)));
            wr    = 1'(rand_bits(1));
            addr  = ram_addr(6'(rand_bits(6)));
            wdata = rand_bits(32);
            ram_access(addr, wdata, op, wr);
        end
        finish_test("ram random access", errs);

        errs = err_cnt;
        for (int i = 0; i < 8; i++) begin
            addr = ram_addr(6'(rand_bits(6)));
            addr[31:28] = {3'(rand_bits(3)), 1'b1};
            wdata = rand_bits(32);
            xfer(addr, wdata, MEM_W, 1'b1, 1'b1, '0, 1'b1, rd);
            xfer(addr, '0, MEM_W, 1'b0, 1'b1, '0, 1'b1, rd);
            addr[31:28] = DMEM_BASE;
            ram_access(addr, '0, MEM_W, 1'b0);
        end
        finish_test("unmapped address", errs);

        errs = err_cnt;
        wdata = rand_bits(32);
        gpio_access(GPIO_OUT, 2'd0, wdata, MEM_W, 1'b1);
        wdata = rand_bits(32);
        gpio_access(GPIO_EN, 2'd0, wdata, MEM_W, 1'b1);
        wdata = rand_bits(32);
        gpio_access(GPIO_OUT, 2'd1, wdata, MEM_B, 1'b1);
        wdata = rand_bits(32);
        gpio_access(GPIO_EN, 2'd2, wdata, MEM_H, 1'b1);
        // Lane 3 lies above the pins
        wdata = rand_bits(32);
        gpio_access(GPIO_OUT, 2'd3, wdata, MEM_B, 1'b1);
        gpio_access(GPIO_OUT, 2'd0, '0, MEM_W, 1'b0);
        gpio_access(GPIO_EN, 2'd0, '0, MEM_W, 1'b0);
        gpio_access(GPIO_OUT, 2'd2, '0, MEM_HU, 1'b0);
        wdata = rand_bits(32);
        @(posedge clk);
        gpio_in <= wdata[GPIO_PINS-1:0];
        exp_gpio_in = wdata[GPIO_PINS-1:0];
        repeat (3) @(posedge clk);
        gpio_access(GPIO_IN, 2'd0, '0, MEM_W, 1'b0);
        finish_test("gpio", errs);

        errs = err_cnt;
        xfer({MTIMER_BASE, 24'h0, MTIME_LO}, '0, MEM_W, 1'b0, 1'b0, '0, 1'b0, rd);
        prev_mtime = rd;
        chk_mtime  = 1'b1;
        xfer({MTIMER_BASE, 24'h0, MTIME_LO}, '0, MEM_W, 1'b0, 1'b0, '0, 1'b0, rd);
        chk_mtime  = 1'b0;
        chk_irq = 1'b1;
        irq_exp = 1'b0;
        timer_write(MTIMECMP_HI, 32'h0);
        irq_exp = 1'b1;
        timer_write(MTIMECMP_LO, 32'h0);
        irq_exp = 1'b0;
        timer_write(MTIMECMP_HI, 32'hffff_ffff);
        chk_irq = 1'b0;
        xfer({MTIMER_BASE, 24'h0, MTIMECMP_HI}, '0, MEM_W, 1'b0, 1'b1, 32'hffff_ffff, 1'b0, rd);
        finish_test("timer", errs);

        $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
                 err_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/periph_soc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module periph_soc_top (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  wb_pkg::mem_req_t              mem_req_i,
    output wb_pkg::mem_rsp_t              mem_rsp_o,
    output logic                          mem_stall_o,
    input  logic [soc_pkg::GPIO_PINS-1:0] gpio_i,
    output logic [soc_pkg::GPIO_PINS-1:0] gpio_o,
    output logic [soc_pkg::GPIO_PINS-1:0] gpio_en_o,
    output logic                          timer_irq_o
);
    import wb_pkg::*;
    import soc_pkg::*;

    wb_m2s_t                  bus_m2s;
    wb_s2m_t                  bus_s2m;
    wb_m2s_t [NUM_SLAVES-1:0] slv_m2s;
    wb_s2m_t [NUM_SLAVES-1:0] slv_s2m;

    // ==========================================================
    // Master side
    // ==========================================================

    wb_master_bridge u_bridge (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .mem_req_i   (mem_req_i),
        .mem_rsp_o   (mem_rsp_o),
        .mem_stall_o (mem_stall_o),
        .wb_o        (bus_m2s),
        .wb_i        (bus_s2m)
    );

    wb_addr_decoder u_decoder (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .m_i     (bus_m2s),
        .m_o     (bus_s2m),
        .s_o     (slv_m2s),
        .s_i     (slv_s2m)
    );

    // ==========================================================
    // Slaves
    // ==========================================================

    wb_data_ram #(
        .DEPTH_WORDS (DMEM_WORDS)
    ) u_dmem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (slv_m2s[DMEM]),
        .wb_o    (slv_s2m[DMEM])
    );

    wb_mtimer u_mtimer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_i        (slv_m2s[MTIMER]),
        .wb_o        (slv_s2m[MTIMER]),
        .timer_irq_o (timer_irq_o)
    );

    wb_gpio_port u_gpio (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wb_i      (slv_m2s[GPIO]),
        .wb_o      (slv_s2m[GPIO]),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_en_o (gpio_en_o)
    );

endmodule

`default_nettype wire

/* source/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // ==========================================================
    // Address map
    // ==========================================================

    // Top nibble of the address picks the slave
    localparam int SLAVE_SEL_HI = 31;
    localparam int SLAVE_SEL_LO = 28;

    localparam logic [3:0] DMEM_BASE   = 4'h0;
    localparam logic [3:0] MTIMER_BASE = 4'h2;
    localparam logic [3:0] GPIO_BASE   = 4'h4;

    // Decoder port order
    typedef enum logic [1:0] {
        DMEM   = 2'd0,
        MTIMER = 2'd1,
        GPIO   = 2'd2
    } slave_e;

    localparam int NUM_SLAVES = 3;

    // ==========================================================
    // Slave sizes and register offsets
    // ==========================================================

    localparam int DMEM_WORDS = 256;
    localparam int GPIO_PINS  = 24;

    // Machine timer, two 64-bit registers in 32-bit halves
    localparam logic [3:0] MTIME_LO    = 4'h0;
    localparam logic [3:0] MTIME_HI    = 4'h4;
    localparam logic [3:0] MTIMECMP_LO = 4'h8;
    localparam logic [3:0] MTIMECMP_HI = 4'hC;

    localparam logic [3:0] GPIO_OUT = 4'h0;
    localparam logic [3:0] GPIO_EN  = 4'h4;
    localparam logic [3:0] GPIO_IN  = 4'h8;

endpackage

`default_nettype wire

/* source/wb_addr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_addr_decoder (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  wb_pkg::wb_m2s_t                          m_i,
    output wb_pkg::wb_s2m_t                          m_o,
    output wb_pkg::wb_m2s_t [soc_pkg::NUM_SLAVES-1:0] s_o,
    input  wb_pkg::wb_s2m_t [soc_pkg::NUM_SLAVES-1:0] s_i
);
    import wb_pkg::*;
    import soc_pkg::*;

    logic [NUM_SLAVES-1:0] hit;
    logic [NUM_SLAVES-1:0] s_stb;
    logic                  err_q;

    always_comb begin
        hit = '0;
        case (m_i.adr[SLAVE_SEL_HI:SLAVE_SEL_LO])
            DMEM_BASE:   hit[DMEM]   = 1'b1;
            MTIMER_BASE: hit[MTIMER] = 1'b1;
            GPIO_BASE:   hit[GPIO]   = 1'b1;
            default:     hit = '0;
        endcase
    end

    // Fan out, strobes only to the addressed slave
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            s_o[i]     = m_i;
            s_o[i].cyc = m_i.cyc & hit[i];
            s_o[i].stb = m_i.stb & hit[i];
            s_stb[i]   = m_i.stb & hit[i];
        end
    end

    // Unmapped address gets its own error reply
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= m_i.cyc && m_i.stb && !(|hit) && !err_q;
        end
    end

    always_comb begin
        m_o = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (hit[i]) begin
                m_o = s_i[i];
            end
        end
        if (err_q) begin
            m_o.ack = 1'b1;
            m_o.err = 1'b1;
        end
    end

    // At most one slave strobe, and never one together with the error reply
    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({s_stb, err_q}));

endmodule

`default_nettype wire

/* source/wb_data_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_data_ram #(
    parameter int DEPTH_WORDS = soc_pkg::DMEM_WORDS
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  wb_pkg::wb_m2s_t wb_i,
    output wb_pkg::wb_s2m_t wb_o
);
    import wb_pkg::*;

    logic [XLEN-1:0]                  mem [DEPTH_WORDS];
    logic [$clog2(DEPTH_WORDS)-1:0]   idx;
    logic [XLEN-1:0]                  rdata_q;
    logic                             ack_q;
    logic                             req;

    // Word index, upper address bits wrap
    assign idx = wb_i.adr[$clog2(DEPTH_WORDS)+1:2];

    // No second access while the ack is out
    assign req = wb_i.cyc & wb_i.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (req && wb_i.we) begin
            mem[idx] <= merge_bytes(mem[idx], wb_i.dat, wb_i.sel);
        end
        if (req) begin
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_comb begin
        wb_o.dat = rdata_q;
        wb_o.ack = ack_q;
        wb_o.err = 1'b0;
    end

endmodule

`default_nettype wire

/* source/wb_gpio_port.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_gpio_port (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  wb_pkg::wb_m2s_t                wb_i,
    output wb_pkg::wb_s2m_t                wb_o,
    input  logic [soc_pkg::GPIO_PINS-1:0]  gpio_i,
    output logic [soc_pkg::GPIO_PINS-1:0]  gpio_o,
    output logic [soc_pkg::GPIO_PINS-1:0]  gpio_en_o
);
    import wb_pkg::*;
    import soc_pkg::*;

    logic [GPIO_PINS-1:0] out_q;
    logic [GPIO_PINS-1:0] en_q;
    logic [GPIO_PINS-1:0] sync1_q;
    logic [GPIO_PINS-1:0] sync2_q;
    logic                 ack_q;
    logic [XLEN-1:0]      rdata_q;
    logic                 req;
    logic [3:0]           reg_off;
    logic [XLEN-1:0]      out_new;
    logic [XLEN-1:0]      en_new;

    assign req     = wb_i.cyc & wb_i.stb & ~ack_q;
    assign reg_off = {wb_i.adr[3:2], 2'b00};

    assign out_new = merge_bytes(XLEN'(out_q), wb_i.dat, wb_i.sel);
    assign en_new  = merge_bytes(XLEN'(en_q), wb_i.dat, wb_i.sel);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_q <= '0;
            en_q  <= '0;
        end else if (req && wb_i.we) begin
            if (reg_off == GPIO_OUT) begin
                out_q <= out_new[GPIO_PINS-1:0];
            end
            if (reg_off == GPIO_EN) begin
                en_q <= en_new[GPIO_PINS-1:0];
            end
        end
    end

    // Two-flop synchronizer for the pad inputs
    always_ff @(posedge clk) begin
        sync1_q <= gpio_i;
        sync2_q <= sync1_q;
    end

    always_ff @(posedge clk) begin
        if (req) begin
            case (reg_off)
                GPIO_OUT: rdata_q <= XLEN'(out_q);
                GPIO_EN:  rdata_q <= XLEN'(en_q);
                GPIO_IN:  rdata_q <= XLEN'(sync2_q);
                default:  rdata_q <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    assign gpio_o    = out_q;
    assign gpio_en_o = en_q;

    always_comb begin
        wb_o.dat = rdata_q;
        wb_o.ack = ack_q;
        wb_o.err = 1'b0;
    end

endmodule

`default_nettype wire

/* source/wb_master_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_master_bridge (
    input  logic              clk,
    input  logic              rst_n_i,
    input  wb_pkg::mem_req_t  mem_req_i,
    output wb_pkg::mem_rsp_t  mem_rsp_o,
    output logic              mem_stall_o,
    output wb_pkg::wb_m2s_t   wb_o,
    input  wb_pkg::wb_s2m_t   wb_i
);
    import wb_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_HOLD
    } state_e;

    state_e           state_q;
    logic             stb_q;
    logic             req_v;
    logic [XLEN-1:0]  adr_q;
    logic [XLEN-1:0]  dat_q;
    logic [SEL_W-1:0] sel_q;
    logic             we_q;
    mem_op_e          op_q;
    logic [SEL_W-1:0] sel_d;
    logic [XLEN-1:0]  wdata_d;
    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;

    assign req_v = mem_req_i.read | mem_req_i.write;

    // ==========================================================
    // Store sizing
    // ==========================================================

    always_comb begin
        case (mem_req_i.op)
            MEM_B, MEM_BU: begin
                sel_d   = 4'b0001 << mem_req_i.addr[1:0];
                wdata_d = {4{mem_req_i.wdata[7:0]}};
            end
            MEM_H, MEM_HU: begin
                sel_d   = mem_req_i.addr[1] ? 4'b1100 : 4'b0011;
                wdata_d = {2{mem_req_i.wdata[15:0]}};
            end
            default: begin
                sel_d   = '1;
                wdata_d = mem_req_i.wdata;
            end
        endcase
    end

    // Control FSM, one transfer in flight
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            stb_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_v) begin
                        state_q <= ST_BUSY;
                        stb_q   <= 1'b1;
                    end
                end
                ST_BUSY: begin
                    if (wb_i.ack) begin
                        state_q <= ST_HOLD;
                        stb_q   <= 1'b0;
                    end
                end
                // request is still up right after ack
                ST_HOLD: begin
                    if (!req_v) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req_v) begin
            adr_q <= mem_req_i.addr;
            dat_q <= wdata_d;
            sel_q <= sel_d;
            we_q  <= mem_req_i.write;
            op_q  <= mem_req_i.op;
        end
    end

    always_comb begin
        wb_o.adr = adr_q;
        wb_o.dat = dat_q;
        wb_o.sel = sel_q;
        wb_o.we  = we_q;
        wb_o.cyc = stb_q;
        wb_o.stb = stb_q;
    end

    // ==========================================================
    // Load alignment and extension
    // ==========================================================

    assign ld_byte = wb_i.dat[{adr_q[1:0], 3'b000} +: 8];
    assign ld_half = wb_i.dat[{adr_q[1], 4'b0000} +: 16];

    always_comb begin
        case (op_q)
            MEM_B:   mem_rsp_o.rdata = {{24{ld_byte[7]}}, ld_byte};
            MEM_BU:  mem_rsp_o.rdata = {24'b0, ld_byte};
            MEM_H:   mem_rsp_o.rdata = {{16{ld_half[15]}}, ld_half};
            MEM_HU:  mem_rsp_o.rdata = {16'b0, ld_half};
            default: mem_rsp_o.rdata = wb_i.dat;
        endcase
        mem_rsp_o.ack = wb_i.ack;
        mem_rsp_o.err = wb_i.err;
    end

    assign mem_stall_o = (state_q == ST_IDLE && req_v) || (state_q == ST_BUSY && !wb_i.ack);

    // Slave or decoder reply must land on a strobe held since the cycle before
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_i.ack |-> stb_q && $past(stb_q));

endmodule

`default_nettype wire

/* source/wb_mtimer.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_mtimer (
    input  logic            clk,
    input  logic            rst_n_i,
    input  wb_pkg::wb_m2s_t wb_i,
    output wb_pkg::wb_s2m_t wb_o,
    output logic            timer_irq_o
);
    import wb_pkg::*;
    import soc_pkg::*;

    logic [63:0]     mtime_q;
    logic [63:0]     mtimecmp_q;
    logic            irq_q;
    logic            ack_q;
    logic [XLEN-1:0] rdata_q;
    logic            req;
    logic            wr;
    logic [3:0]      reg_off;
    logic [XLEN-1:0] cmp_lo_new;
    logic [XLEN-1:0] cmp_hi_new;

    assign req     = wb_i.cyc & wb_i.stb & ~ack_q;
    assign wr      = req & wb_i.we;
    assign reg_off = {wb_i.adr[3:2], 2'b00};

    assign cmp_lo_new = merge_bytes(mtimecmp_q[31:0], wb_i.dat, wb_i.sel);
    assign cmp_hi_new = merge_bytes(mtimecmp_q[63:32], wb_i.dat, wb_i.sel);

    // ==========================================================
    // Counter and compare
    // ==========================================================

    // mtime ignores bus writes
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mtimecmp_q <= '1;
        end else if (wr) begin
            if (reg_off == MTIMECMP_LO) begin
                mtimecmp_q[31:0] <= cmp_lo_new;
            end
            if (reg_off == MTIMECMP_HI) begin
                mtimecmp_q[63:32] <= cmp_hi_new;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign timer_irq_o = irq_q;

    // ==========================================================
    // Bus read
    // ==========================================================

    always_ff @(posedge clk) begin
        if (req) begin
            case (reg_off)
                MTIME_LO:    rdata_q <= mtime_q[31:0];
                MTIME_HI:    rdata_q <= mtime_q[63:32];
                MTIMECMP_LO: rdata_q <= mtimecmp_q[31:0];
                MTIMECMP_HI: rdata_q <= mtimecmp_q[63:32];
                default:     rdata_q <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_comb begin
        wb_o.dat = rdata_q;
        wb_o.ack = ack_q;
        wb_o.err = 1'b0;
    end

endmodule

`default_nettype wire

/* source/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    localparam int XLEN  = 32;
    localparam int SEL_W = 4;

    // Same codes as funct3 of the RISC-V load/store opcodes
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_op_e;

    // ==========================================================
    // Processor port
    // ==========================================================

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        mem_op_e         op;
        logic            read;
        logic            write;
    } mem_req_t;

    typedef struct packed {
        logic [XLEN-1:0] rdata;
        logic            ack;
        logic            err;
    } mem_rsp_t;

    // ==========================================================
    // Wishbone
    // ==========================================================

    typedef struct packed {
        logic [XLEN-1:0]  adr;
        logic [XLEN-1:0]  dat;
        logic [SEL_W-1:0] sel;
        logic             we;
        logic             cyc;
        logic             stb;
    } wb_m2s_t;

    typedef struct packed {
        logic [XLEN-1:0] dat;
        logic            ack;
        logic            err;
    } wb_s2m_t;

    // Byte-lane merge used by every writable slave register
    function automatic logic [XLEN-1:0] merge_bytes(
        input logic [XLEN-1:0]  old_w,
        input logic [XLEN-1:0]  new_w,
        input logic [SEL_W-1:0] sel
    );
        logic [XLEN-1:0] res;
        res = old_w;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* tb.f */
source/wb_pkg.sv
source/soc_pkg.sv
source/wb_master_bridge.sv
source/wb_addr_decoder.sv
source/wb_data_ram.sv
source/wb_mtimer.sv
source/wb_gpio_port.sv
source/periph_soc_top.sv
sim/tb_periph_soc.sv
